// ==== Makefile ====
TOP = tb_deparser

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

obj_dir/V$(TOP): compile.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== action_pkg.sv ====
`include "deparser_config.svh"

package action_pkg;

	// container size selector, byte count is twice the code
	typedef enum logic [1:0] {
		NONE = 2'd0,
		B2   = 2'd1,
		B4   = 2'd2,
		B6   = 2'd3
	} cont_kind_t;

	typedef struct packed {
		logic       en;
		cont_kind_t kind;
		logic [1:0] cont_idx;
		// byte offset into the header, MSB of the container goes here
		logic [5:0] offset;
		logic [4:0] rsvd;
	} action_t;

	// action 0 in the low 16 bits
	typedef action_t [`NUM_ACTIONS-1:0] action_row_t;

	typedef logic [$clog2(`TBL_DEPTH)-1:0] tbl_idx_t;

	typedef struct packed {
		logic [`NUM_CONT-1:0][47:0] c6;
		logic [`NUM_CONT-1:0][31:0] c4;
		logic [`NUM_CONT-1:0][15:0] c2;
		tbl_idx_t                   tbl_idx;
	} phv_t;

endpackage

// ==== action_table.sv ====
`timescale 1ns/1ps
`include "deparser_config.svh"

module action_table (
	input  logic                    clk,
	input  logic                    aresetn,
	input  logic [`DATA_W-1:0]      c_s_axis_tdata,
	input  logic                    c_s_axis_tvalid,
	input  logic                    c_s_axis_tlast,
	input  action_pkg::tbl_idx_t    rd_idx,
	output action_pkg::action_row_t rd_row
);
	import action_pkg::*;

	typedef enum logic {C_IDLE, C_WRITE} c_state_t;

	c_state_t    c_state;
	logic        mid_pkt;
	logic        hdr_match;
	tbl_idx_t    cur_idx;
	logic        wr_en;
	tbl_idx_t    wr_idx;
	action_row_t wr_row;
	action_row_t mem [`TBL_DEPTH];

	// only the first beat of a control packet can open a table write
	assign hdr_match = !mid_pkt &&
		c_s_axis_tdata[`CTRL_FLAG_LSB +: 16] == `CTRL_FLAG &&
		c_s_axis_tdata[`CTRL_MOD_LSB +: 3] == `DEPARSER_ID;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			mid_pkt <= 1'b0;
		end else if (c_s_axis_tvalid) begin
			mid_pkt <= !c_s_axis_tlast;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			c_state <= C_IDLE;
			cur_idx <= '0;
			wr_en   <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			case (c_state)
				C_IDLE: begin
					if (c_s_axis_tvalid && hdr_match && !c_s_axis_tlast) begin
						cur_idx <= c_s_axis_tdata[`CTRL_IDX_LSB +: $bits(tbl_idx_t)];
						c_state <= C_WRITE;
					end
				end
				C_WRITE: begin
					if (c_s_axis_tvalid) begin
						wr_en   <= 1'b1;
						cur_idx <= cur_idx + 1'b1;
						if (c_s_axis_tlast) begin
							c_state <= C_IDLE;
						end
					end
				end
				default: c_state <= C_IDLE;
			endcase
		end
	end

	// row taken from the low bits of each data beat
	always_ff @(posedge clk) begin
		if (c_state == C_WRITE && c_s_axis_tvalid) begin
			wr_idx <= cur_idx;
			wr_row <= c_s_axis_tdata[$bits(action_row_t)-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_idx] <= wr_row;
		end
		rd_row <= mem[rd_idx];
	end

endmodule

// ==== compile.f ====
+incdir+.
stream_pkg.sv
action_pkg.sv
hdr_if.sv
action_table.sv
header_rewriter.sv
stream_out.sv
deparser_top.sv
deparser_assertions.sv
tb_deparser.sv

// ==== deparser_assertions.sv ====
`timescale 1ns/1ps
`include "deparser_config.svh"

module deparser_assertions (
	input logic               clk,
	input logic               aresetn,
	input logic [`DATA_W-1:0] depar_out_tdata,
	input logic [`KEEP_W-1:0] depar_out_tkeep,
	input logic [`USER_W-1:0] depar_out_tuser,
	input logic               depar_out_tvalid,
	input logic               depar_out_tlast,
	input logic               depar_out_tready,
	input logic               pkt_fifo_rd_en,
	input logic               pkt_fifo_empty,
	input logic               phv_fifo_rd_en,
	input logic               phv_fifo_empty
);

	// output quiet on the first edge out of reset
	tvalid_after_reset: assert property (@(posedge clk) $rose(aresetn) |-> !depar_out_tvalid)
		else $error("depar_out_tvalid high right after reset");

	// held beat under back-pressure
	beat_stable: assert property (@(posedge clk) disable iff (!aresetn)
		depar_out_tvalid && !depar_out_tready |=> depar_out_tvalid &&
		$stable(depar_out_tdata) && $stable(depar_out_tkeep) &&
		$stable(depar_out_tuser) && $stable(depar_out_tlast))
		else $error("output beat changed while stalled");

	pkt_pop_nonempty: assert property (@(posedge clk) disable iff (!aresetn)
		pkt_fifo_rd_en |-> !pkt_fifo_empty)
		else $error("pkt_fifo_rd_en while packet FIFO empty");

	phv_pop_nonempty: assert property (@(posedge clk) disable iff (!aresetn)
		phv_fifo_rd_en |-> !phv_fifo_empty)
		else $error("phv_fifo_rd_en while PHV FIFO empty");

endmodule

// ==== deparser_config.svh ====
`ifndef DEPARSER_CONFIG_SVH
`define DEPARSER_CONFIG_SVH

// stream widths
`define DATA_W 128
`define USER_W 16
`define KEEP_W (`DATA_W / 8)

// header capture and action table
`define HDR_BEATS 2
`define NUM_ACTIONS 4
`define ACTION_W 16
`define TBL_DEPTH 16

// containers of each size in the PHV
`define NUM_CONT 4

// control packet recognition
`define CTRL_FLAG 16'hf2f1
`define DEPARSER_ID 3'b101

// field positions in the first control beat
`define CTRL_FLAG_LSB 0
`define CTRL_MOD_LSB 16
`define CTRL_IDX_LSB 24

`endif

// ==== deparser_top.sv ====
`timescale 1ns/1ps
`include "deparser_config.svh"

module deparser_top (
	input  logic               clk,
	input  logic               aresetn,
	input  logic [`DATA_W-1:0] pkt_fifo_tdata,
	input  logic [`KEEP_W-1:0] pkt_fifo_tkeep,
	input  logic [`USER_W-1:0] pkt_fifo_tuser,
	input  logic               pkt_fifo_tlast,
	input  logic               pkt_fifo_empty,
	output logic               pkt_fifo_rd_en,
	input  action_pkg::phv_t   phv_fifo_data,
	input  logic               phv_fifo_empty,
	output logic               phv_fifo_rd_en,
	output logic [`DATA_W-1:0] depar_out_tdata,
	output logic [`KEEP_W-1:0] depar_out_tkeep,
	output logic [`USER_W-1:0] depar_out_tuser,
	output logic               depar_out_tvalid,
	output logic               depar_out_tlast,
	input  logic               depar_out_tready,
	input  logic [`DATA_W-1:0] c_s_axis_tdata,
	input  logic               c_s_axis_tvalid,
	input  logic               c_s_axis_tlast
);
	import action_pkg::*;

	tbl_idx_t    rd_idx;
	action_row_t rd_row;

	hdr_if hdr_bus ();

	action_table action_table_i (
		.clk             (clk),
		.aresetn         (aresetn),
		.c_s_axis_tdata  (c_s_axis_tdata),
		.c_s_axis_tvalid (c_s_axis_tvalid),
		.c_s_axis_tlast  (c_s_axis_tlast),
		.rd_idx          (rd_idx),
		.rd_row          (rd_row)
	);

	header_rewriter header_rewriter_i (
		.clk            (clk),
		.aresetn        (aresetn),
		.pkt_fifo_tdata (pkt_fifo_tdata),
		.pkt_fifo_tkeep (pkt_fifo_tkeep),
		.pkt_fifo_tuser (pkt_fifo_tuser),
		.pkt_fifo_tlast (pkt_fifo_tlast),
		.pkt_fifo_empty (pkt_fifo_empty),
		.pkt_fifo_rd_en (pkt_fifo_rd_en),
		.phv_fifo_data  (phv_fifo_data),
		.phv_fifo_empty (phv_fifo_empty),
		.phv_fifo_rd_en (phv_fifo_rd_en),
		.rd_idx         (rd_idx),
		.rd_row         (rd_row),
		.hdr            (hdr_bus.producer)
	);

	stream_out stream_out_i (
		.clk              (clk),
		.aresetn          (aresetn),
		.hdr              (hdr_bus.consumer),
		.pkt_fifo_tdata   (pkt_fifo_tdata),
		.pkt_fifo_tkeep   (pkt_fifo_tkeep),
		.pkt_fifo_tuser   (pkt_fifo_tuser),
		.pkt_fifo_tlast   (pkt_fifo_tlast),
		.pkt_fifo_empty   (pkt_fifo_empty),
		.depar_out_tdata  (depar_out_tdata),
		.depar_out_tkeep  (depar_out_tkeep),
		.depar_out_tuser  (depar_out_tuser),
		.depar_out_tvalid (depar_out_tvalid),
		.depar_out_tlast  (depar_out_tlast),
		.depar_out_tready (depar_out_tready)
	);

endmodule

// ==== hdr_if.sv ====
`timescale 1ns/1ps
`include "deparser_config.svh"

interface hdr_if;
	import stream_pkg::*;

	// rewritten header, stable while hdr_valid is high
	header_t hdr;
	logic    hdr_valid;

	// pulses on the last header beat and on the packet's tlast beat
	logic    hdr_done;

	// body beat taken from the packet FIFO
	logic    body_pop;

	modport producer (
		output hdr,
		output hdr_valid,
		input  hdr_done,
		input  body_pop
	);

	modport consumer (
		input  hdr,
		input  hdr_valid,
		output hdr_done,
		output body_pop
	);

endinterface

// ==== header_rewriter.sv ====
`timescale 1ns/1ps
`include "deparser_config.svh"

module header_rewriter (
	input  logic                    clk,
	input  logic                    aresetn,
	input  logic [`DATA_W-1:0]      pkt_fifo_tdata,
	input  logic [`KEEP_W-1:0]      pkt_fifo_tkeep,
	input  logic [`USER_W-1:0]      pkt_fifo_tuser,
	input  logic                    pkt_fifo_tlast,
	input  logic                    pkt_fifo_empty,
	output logic                    pkt_fifo_rd_en,
	input  action_pkg::phv_t        phv_fifo_data,
	input  logic                    phv_fifo_empty,
	output logic                    phv_fifo_rd_en,
	output action_pkg::tbl_idx_t    rd_idx,
	input  action_pkg::action_row_t rd_row,
	hdr_if.producer                 hdr
);
	import stream_pkg::*;
	import action_pkg::*;

	localparam int HDR_BYTES = `HDR_BEATS * `KEEP_W;

	typedef enum logic [2:0] {
		S_IDLE, S_CAP0, S_CAP1, S_TBL_WAIT, S_REWRITE, S_HOLD
	} state_t;

	state_t                    state;
	logic                      hdr_valid;
	header_t                   hdr_r;
	phv_t                      phv_r;
	beat_t                     in_beat;
	logic                      cap_pop;
	logic                      hdr_has_last;
	logic [HDR_BYTES-1:0][7:0] hdr_bytes;

	assign in_beat = '{data: pkt_fifo_tdata, keep: pkt_fifo_tkeep,
		user: pkt_fifo_tuser, last: pkt_fifo_tlast};

	assign cap_pop = state == S_CAP0 || (state == S_CAP1 && !pkt_fifo_empty);
	assign pkt_fifo_rd_en = cap_pop || hdr.body_pop;
	assign phv_fifo_rd_en = state == S_REWRITE;

	// PHV stays at the FIFO head until the rewrite, so the index holds
	assign rd_idx = phv_fifo_data.tbl_idx;

	assign hdr.hdr = hdr_r;
	assign hdr.hdr_valid = hdr_valid;
	assign hdr_has_last = hdr_r[0].last || hdr_r[1].last;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state     <= S_IDLE;
			hdr_valid <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (!pkt_fifo_empty && !phv_fifo_empty) begin
						state <= S_CAP0;
					end
				end
				S_CAP0: state <= pkt_fifo_tlast ? S_TBL_WAIT : S_CAP1;
				S_CAP1: begin
					if (!pkt_fifo_empty) begin
						state <= S_TBL_WAIT;
					end
				end
				S_TBL_WAIT: state <= S_REWRITE;
				S_REWRITE: begin
					state     <= S_HOLD;
					hdr_valid <= 1'b1;
				end
				S_HOLD: begin
					// second pulse marks the end of the body
					if (hdr.hdr_done) begin
						hdr_valid <= 1'b0;
						if (!hdr_valid || hdr_has_last) begin
							state <= S_IDLE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_CAP0: begin
				hdr_r[0] <= in_beat;
				phv_r    <= phv_fifo_data;
			end
			S_CAP1: begin
				if (!pkt_fifo_empty) begin
					hdr_r[1] <= in_beat;
				end
			end
			S_REWRITE: begin
				for (int b = 0; b < `HDR_BEATS; b++) begin
					hdr_r[b].data <= hdr_bytes[b*`KEEP_W +: `KEEP_W];
				end
				// single beat packet, second beat carries nothing
				if (hdr_r[0].last) begin
					hdr_r[1].keep <= '0;
				end
			end
			default: ;
		endcase
	end

	// patch containers in action order, later actions win
	always_comb begin
		action_t     act;
		logic [47:0] cont_val;
		logic [2:0]  len;
		logic [6:0]  pos;
		for (int b = 0; b < `HDR_BEATS; b++) begin
			hdr_bytes[b*`KEEP_W +: `KEEP_W] = hdr_r[b].data;
		end
		for (int a = 0; a < `NUM_ACTIONS; a++) begin
			act = rd_row[a];
			len = {act.kind, 1'b0};
			// left aligned, first byte in bits 47:40
			case (act.kind)
				B2:   cont_val = {phv_r.c2[act.cont_idx], 32'h0};
				B4:   cont_val = {phv_r.c4[act.cont_idx], 16'h0};
				B6:   cont_val = phv_r.c6[act.cont_idx];
				NONE: cont_val = '0;
			endcase
			for (int j = 0; j < 6; j++) begin
				pos = 7'(act.offset) + 7'(j);
				if (act.en && j < len && pos < HDR_BYTES) begin
					hdr_bytes[pos[$clog2(HDR_BYTES)-1:0]] = cont_val[47-8*j -: 8];
				end
			end
		end
	end

endmodule

// ==== stream_out.sv ====
`timescale 1ns/1ps
`include "deparser_config.svh"

module stream_out (
	input  logic               clk,
	input  logic               aresetn,
	hdr_if.consumer            hdr,
	input  logic [`DATA_W-1:0] pkt_fifo_tdata,
	input  logic [`KEEP_W-1:0] pkt_fifo_tkeep,
	input  logic [`USER_W-1:0] pkt_fifo_tuser,
	input  logic               pkt_fifo_tlast,
	input  logic               pkt_fifo_empty,
	output logic [`DATA_W-1:0] depar_out_tdata,
	output logic [`KEEP_W-1:0] depar_out_tkeep,
	output logic [`USER_W-1:0] depar_out_tuser,
	output logic               depar_out_tvalid,
	output logic               depar_out_tlast,
	input  logic               depar_out_tready
);
	import stream_pkg::*;

	typedef enum logic [1:0] {P_WAIT, P_HDR0, P_HDR1, P_BODY} phase_t;

	phase_t phase;
	beat_t  out_beat;
	logic   out_valid;
	logic   accept;

	// header beats come from the held header, body straight off the FIFO head
	always_comb begin
		out_beat  = hdr.hdr[0];
		out_valid = 1'b0;
		case (phase)
			P_HDR0: out_valid = 1'b1;
			P_HDR1: begin
				out_beat  = hdr.hdr[1];
				out_valid = 1'b1;
			end
			P_BODY: begin
				out_beat = '{data: pkt_fifo_tdata, keep: pkt_fifo_tkeep,
					user: pkt_fifo_tuser, last: pkt_fifo_tlast};
				out_valid = !pkt_fifo_empty;
			end
			default: ;
		endcase
	end

	assign accept = out_valid && depar_out_tready;

	assign depar_out_tdata  = out_beat.data;
	assign depar_out_tkeep  = out_beat.keep;
	assign depar_out_tuser  = out_beat.user;
	assign depar_out_tlast  = out_beat.last;
	assign depar_out_tvalid = out_valid;

	assign hdr.body_pop = accept && phase == P_BODY;
	// beat 1 is always the last header beat, otherwise only tlast ends a stage
	assign hdr.hdr_done = accept && (phase == P_HDR1 || out_beat.last);

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			phase <= P_WAIT;
		end else begin
			case (phase)
				P_WAIT: begin
					if (hdr.hdr_valid) begin
						phase <= P_HDR0;
					end
				end
				P_HDR0: begin
					if (accept) begin
						phase <= out_beat.last ? P_WAIT : P_HDR1;
					end
				end
				default: begin
					if (accept) begin
						phase <= out_beat.last ? P_WAIT : P_BODY;
					end
				end
			endcase
		end
	end

endmodule

// ==== stream_pkg.sv ====
`include "deparser_config.svh"

package stream_pkg;

	// one beat of the packet stream as it sits in the FIFO
	typedef struct packed {
		logic [`DATA_W-1:0] data;
		logic [`KEEP_W-1:0] keep;
		logic [`USER_W-1:0] user;
		logic               last;
	} beat_t;

	// captured header, beat 0 in element 0
	// header byte k lives in data bits 8k of beat k/KEEP_W
	typedef beat_t [`HDR_BEATS-1:0] header_t;

endpackage

// ==== tb_deparser.sv ====
`timescale 1ns/1ps
`include "deparser_config.svh"

module tb_deparser;
	import stream_pkg::*;
	import action_pkg::*;

	// data and control packets sent below
	localparam int NUM_PKTS = 39;
	localparam int TIMEOUT_CYCLES = 200 * NUM_PKTS;
	localparam int HDR_BYTES = `HDR_BEATS * `KEEP_W;

	logic               clk;
	logic               aresetn;
	logic [`DATA_W-1:0] pkt_fifo_tdata;
	logic [`KEEP_W-1:0] pkt_fifo_tkeep;
	logic [`USER_W-1:0] pkt_fifo_tuser;
	logic               pkt_fifo_tlast;
	logic               pkt_fifo_empty;
	logic               pkt_fifo_rd_en;
	phv_t               phv_fifo_data;
	logic               phv_fifo_empty;
	logic               phv_fifo_rd_en;
	logic [`DATA_W-1:0] depar_out_tdata;
	logic [`KEEP_W-1:0] depar_out_tkeep;
	logic [`USER_W-1:0] depar_out_tuser;
	logic               depar_out_tvalid;
	logic               depar_out_tlast;
	logic               depar_out_tready;
	logic [`DATA_W-1:0] c_s_axis_tdata;
	logic               c_s_axis_tvalid;
	logic               c_s_axis_tlast;

	beat_t       pkt_q [$];
	phv_t        phv_q [$];
	beat_t       exp_q [$];
	action_row_t shadow [`TBL_DEPTH];
	action_row_t ctrl_rows [`TBL_DEPTH];
	beat_t       mon_got;
	beat_t       mon_exp;
	logic        pkt_pop;
	logic        phv_pop;
	logic        bp_en;
	int          sent_beats;
	int          rx_beats;
	int          cycles;

	deparser_top deparser_top_i (.*);

	bind deparser_top deparser_assertions deparser_assertions_i (
		.clk              (clk),
		.aresetn          (aresetn),
		.depar_out_tdata  (depar_out_tdata),
		.depar_out_tkeep  (depar_out_tkeep),
		.depar_out_tuser  (depar_out_tuser),
		.depar_out_tvalid (depar_out_tvalid),
		.depar_out_tlast  (depar_out_tlast),
		.depar_out_tready (depar_out_tready),
		.pkt_fifo_rd_en   (pkt_fifo_rd_en),
		.pkt_fifo_empty   (pkt_fifo_empty),
		.phv_fifo_rd_en   (phv_fifo_rd_en),
		.phv_fifo_empty   (phv_fifo_empty)
	);

	always #2 clk = ~clk;

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_beat(input beat_t got, input beat_t exp, input int idx);
		logic bad;
		bad = 1'b0;
		if (got.data !== exp.data) begin
			$display("Error: beat %0d depar_out_tdata %h expected %h", idx, got.data, exp.data);
			bad = 1'b1;
		end
		if (got.keep !== exp.keep) begin
			$display("Error: beat %0d depar_out_tkeep %h expected %h", idx, got.keep, exp.keep);
			bad = 1'b1;
		end
		if (got.user !== exp.user) begin
			$display("Error: beat %0d depar_out_tuser %h expected %h", idx, got.user, exp.user);
			bad = 1'b1;
		end
		if (got.last !== exp.last) begin
			$display("Error: beat %0d depar_out_tlast %h expected %h", idx, got.last, exp.last);
			bad = 1'b1;
		end
		if (bad) begin
			abort_run();
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("Error: %s %h expected %h", what, got, exp);
			abort_run();
		end
	endtask

	// expected header with each container MSB first at its action offset
	function automatic header_t expect_header(input phv_t phv, input header_t hin,
		input action_row_t row);
		logic [7:0]  bytes [HDR_BYTES];
		header_t     hout;
		logic [47:0] val;
		int          n;
		int          pos;
		hout = hin;
		for (int k = 0; k < HDR_BYTES; k++) begin
			bytes[k] = hin[k / `KEEP_W].data[8*(k % `KEEP_W) +: 8];
		end
		for (int a = 0; a < `NUM_ACTIONS; a++) begin
			case (row[a].kind)
				B2: begin
					n = 2;
					val = 48'(phv.c2[row[a].cont_idx]);
				end
				B4: begin
					n = 4;
					val = 48'(phv.c4[row[a].cont_idx]);
				end
				B6: begin
					n = 6;
					val = phv.c6[row[a].cont_idx];
				end
				default: begin
					n = 0;
					val = '0;
				end
			endcase
			if (!row[a].en) begin
				n = 0;
			end
			for (int i = 0; i < n; i++) begin
				pos = int'(row[a].offset) + i;
				// bytes past the header are lost
				if (pos < HDR_BYTES) begin
					bytes[pos] = val[8*(n-1-i) +: 8];
				end
			end
		end
		for (int k = 0; k < HDR_BYTES; k++) begin
			hout[k / `KEEP_W].data[8*(k % `KEEP_W) +: 8] = bytes[k];
		end
		if (hin[0].last) begin
			hout[1].keep = '0;
		end
		return hout;
	endfunction

	function automatic action_t make_action(input logic en, input cont_kind_t kind,
		input logic [1:0] idx, input logic [5:0] off);
		action_t act;
		act.en = en;
		act.kind = kind;
		act.cont_idx = idx;
		act.offset = off;
		act.rsvd = '0;
		return act;
	endfunction

	function automatic action_row_t random_row();
		action_row_t row;
		for (int a = 0; a < `NUM_ACTIONS; a++) begin
			row[a] = action_t'(16'($urandom));
			// mostly inside the header with a few hanging over the end
			row[a].offset = 6'($urandom % 34);
		end
		return row;
	endfunction

	// pushes packet and PHV and queues the expected output beats
	task automatic send_packet(input int nbeats, input tbl_idx_t idx);
		beat_t            beats [$];
		beat_t            b;
		logic [13*32-1:0] rnd;
		phv_t             phv;
		header_t          hin;
		header_t          hexp;
		for (int i = 0; i < nbeats; i++) begin
			b.data = {$urandom, $urandom, $urandom, $urandom};
			b.keep = (i == nbeats - 1) ? (`KEEP_W'($urandom) | 1) : '1;
			b.user = `USER_W'($urandom);
			b.last = i == nbeats - 1;
			beats.push_back(b);
		end
		for (int w = 0; w < 13; w++) begin
			rnd[32*w +: 32] = $urandom;
		end
		phv = rnd[$bits(phv_t)-1:0];
		phv.tbl_idx = idx;
		hin[0] = beats[0];
		hin[1] = (nbeats > 1) ? beats[1] : '0;
		hexp = expect_header(phv, hin, shadow[idx]);
		exp_q.push_back(hexp[0]);
		if (nbeats > 1) begin
			exp_q.push_back(hexp[1]);
		end
		for (int i = 2; i < nbeats; i++) begin
			exp_q.push_back(beats[i]);
		end
		foreach (beats[i]) begin
			pkt_q.push_back(beats[i]);
		end
		phv_q.push_back(phv);
		sent_beats += nbeats;
	endtask

	// flag, id and start index first and then one row per beat
	task automatic send_ctrl(input logic [15:0] flag, input logic [2:0] mod_id,
		input tbl_idx_t start, input int count);
		logic [`DATA_W-1:0] first;
		first = '0;
		first[`CTRL_FLAG_LSB +: 16] = flag;
		first[`CTRL_MOD_LSB +: 3] = mod_id;
		first[`CTRL_IDX_LSB +: $bits(tbl_idx_t)] = start;
		@(posedge clk);
		#1;
		c_s_axis_tdata = first;
		c_s_axis_tvalid = 1'b1;
		c_s_axis_tlast = 1'b0;
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#1;
			// upper bits are noise
			c_s_axis_tdata = {$urandom, $urandom, ctrl_rows[i]};
			c_s_axis_tlast = i == count - 1;
		end
		@(posedge clk);
		#1;
		c_s_axis_tvalid = 1'b0;
		c_s_axis_tlast = 1'b0;
		if (flag == `CTRL_FLAG && mod_id == `DEPARSER_ID) begin
			for (int i = 0; i < count; i++) begin
				shadow[tbl_idx_t'(int'(start) + i)] = ctrl_rows[i];
			end
		end
		repeat (3) @(posedge clk);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		check_count("pkt_fifo level", pkt_q.size(), 0);
		check_count("phv_fifo level", phv_q.size(), 0);
	endtask

	// FWFT FIFO models that pop on the rd_en seen mid cycle
	always @(negedge clk) begin
		pkt_pop <= pkt_fifo_rd_en;
		phv_pop <= phv_fifo_rd_en;
	end

	always @(posedge clk) begin
		#1;
		if (pkt_pop === 1'b1) begin
			if (pkt_q.size() == 0) begin
				$display("packet FIFO was read while empty");
				abort_run();
			end else begin
				void'(pkt_q.pop_front());
			end
		end
		if (phv_pop === 1'b1) begin
			if (phv_q.size() == 0) begin
				$display("PHV FIFO was read while empty");
				abort_run();
			end else begin
				void'(phv_q.pop_front());
			end
		end
		pkt_fifo_empty = pkt_q.size() == 0;
		if (pkt_q.size() != 0) begin
			pkt_fifo_tdata = pkt_q[0].data;
			pkt_fifo_tkeep = pkt_q[0].keep;
			pkt_fifo_tuser = pkt_q[0].user;
			pkt_fifo_tlast = pkt_q[0].last;
		end
		phv_fifo_empty = phv_q.size() == 0;
		if (phv_q.size() != 0) begin
			phv_fifo_data = phv_q[0];
		end
		depar_out_tready = bp_en ? ($urandom % 4 != 0) : 1'b1;
	end

	// compare every accepted output beat in order
	always @(negedge clk) begin
		if (aresetn && depar_out_tvalid && depar_out_tready) begin
			mon_got.data = depar_out_tdata;
			mon_got.keep = depar_out_tkeep;
			mon_got.user = depar_out_tuser;
			mon_got.last = depar_out_tlast;
			rx_beats++;
			if (exp_q.size() == 0) begin
				$display("output beat %0d arrived with no packet outstanding", rx_beats);
				abort_run();
			end else begin
				mon_exp = exp_q.pop_front();
				check_beat(mon_got, mon_exp, rx_beats - 1);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d beats received",
				cycles, rx_beats, sent_beats);
			abort_run();
		end
	end

	initial begin
		void'($urandom(73));
		clk = 1'b0;
		aresetn = 1'b0;
		pkt_fifo_tdata = '0;
		pkt_fifo_tkeep = '0;
		pkt_fifo_tuser = '0;
		pkt_fifo_tlast = 1'b0;
		pkt_fifo_empty = 1'b1;
		phv_fifo_data = '0;
		phv_fifo_empty = 1'b1;
		depar_out_tready = 1'b1;
		c_s_axis_tdata = '0;
		c_s_axis_tvalid = 1'b0;
		c_s_axis_tlast = 1'b0;
		pkt_pop = 1'b0;
		phv_pop = 1'b0;
		bp_en = 1'b0;
		sent_beats = 0;
		rx_beats = 0;
		cycles = 0;
		repeat (5) @(posedge clk);
		#1;
		aresetn = 1'b1;

		// fill the whole table with rows 1 and 2 directed
		for (int i = 0; i < `TBL_DEPTH; i++) begin
			ctrl_rows[i] = random_row();
		end
		ctrl_rows[1][0] = make_action(1'b1, B2, 2'd3, 6'd0);
		ctrl_rows[1][1] = make_action(1'b1, B4, 2'd1, 6'd5);
		ctrl_rows[1][2] = make_action(1'b1, B6, 2'd2, 6'd9);
		ctrl_rows[1][3] = make_action(1'b1, B6, 2'd0, 6'd12);
		// boundary crossing plus disabled, overlapping and truncated actions
		ctrl_rows[2][0] = make_action(1'b1, B6, 2'd1, 6'd13);
		ctrl_rows[2][1] = make_action(1'b0, B4, 2'd0, 6'd2);
		ctrl_rows[2][2] = make_action(1'b1, B2, 2'd2, 6'd15);
		ctrl_rows[2][3] = make_action(1'b1, B4, 2'd3, 6'd30);
		send_ctrl(`CTRL_FLAG, `DEPARSER_ID, 4'd0, `TBL_DEPTH);

		// one-beat packets with every container kind
		repeat (3) send_packet(1, 4'd1);
		wait_drain();

		// two-beat headers
		send_packet(2, 4'd2);
		send_packet(3, 4'd2);
		wait_drain();

		// long bodies pass through
		repeat (5) send_packet(6 + int'($urandom % 5), tbl_idx_t'($urandom));
		wait_drain();

		// random back-pressure
		bp_en = 1'b1;
		repeat (15) send_packet(1 + int'($urandom % 8), tbl_idx_t'($urandom));
		wait_drain();

		// foreign control packets must not touch the table
		for (int i = 0; i < `TBL_DEPTH; i++) begin
			ctrl_rows[i] = random_row();
		end
		send_ctrl(`CTRL_FLAG ^ 16'h0001, `DEPARSER_ID, 4'd0, `TBL_DEPTH);
		send_ctrl(`CTRL_FLAG, `DEPARSER_ID ^ 3'b001, 4'd0, `TBL_DEPTH);
		// index wraps from 15 to 0
		send_ctrl(`CTRL_FLAG, `DEPARSER_ID, 4'd14, 4);
		repeat (10) send_packet(1 + int'($urandom % 5), tbl_idx_t'($urandom));
		wait_drain();

		$display(">>> PASS");
		$finish;
	end

endmodule
